//--- dv/piano_ctrl_tb.sv
// Piano control testbench: datapath stand-in, menu walks and game, practice checks
`timescale 1ns/1ps
`default_nettype none

module piano_ctrl_tb
    import piano_ctrl_pkg::*;
();

    logic         clock = 1'b0;
    logic         reset;
    logic         start;
    logic         enter;
    menu_choice_u choice;
    play_status_t status;
    play_ctrl_t   ctrl;
    menu_ctrl_t   menu;
    logic         won;
    logic         lost;
    logic         player_turn;

    logic key_held;
    logic key_correct;
    logic timing_ok;
    logic free_phase;
    logic pb_phase;
    logic shown_flag;
    int   pause_cnt;
    int   pause_len;
    int   metro_cnt;
    int   note_len;
    int   timeout_cnt;
    int   addr;
    int   round_num;
    int   seed = 21;
    int   errors = 0;
    int   lost_pulses;
    int   step_pulses;
    int   n;

    piano_ctrl_top piano_ctrl_top_i (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .enter       (enter),
        .choice      (choice),
        .status      (status),
        .ctrl        (ctrl),
        .menu        (menu),
        .won         (won),
        .lost        (lost),
        .player_turn (player_turn)
    );

    always #10 clock = ~clock;

    // ----------------------------------------
    // Datapath stand-in
    // ----------------------------------------

    always @(negedge clock) begin
        if (reset) begin
            pause_cnt   <= 0;
            pause_len   <= 1;
            metro_cnt   <= 0;
            note_len    <= 1;
            timeout_cnt <= 0;
            addr        <= 0;
            round_num   <= 0;
        end else begin
            if (ctrl.clear_pause) begin
                pause_cnt <= 0;
                pause_len <= 1 + ({$random(seed)} % 4);
            end else if (ctrl.count_pause) begin
                pause_cnt <= pause_cnt + 1;
            end
            if (ctrl.clear_metro) begin
                metro_cnt <= 0;
                note_len  <= 1 + ({$random(seed)} % 4);
            end else if (ctrl.count_metro) begin
                metro_cnt <= metro_cnt + 1;
            end
            if (ctrl.clear_timeout) timeout_cnt <= 0;
            else if (ctrl.count_timeout) timeout_cnt <= timeout_cnt + 1;
            if (ctrl.clear_addr) addr <= 0;
            else if (ctrl.step_addr) addr <= addr + 1;
            if (ctrl.clear_round) round_num <= 0;
            else if (ctrl.step_round) round_num <= round_num + 1;
        end
    end

    // Song of two rounds in the game, three notes in playback
    always_comb begin
        status               = '0;
        status.pause_done    = (pause_cnt >= pause_len);
        status.note_shown    = (metro_cnt >= note_len);
        status.addr_is_round = (addr == round_num);
        status.key_held      = key_held;
        status.key_correct   = key_correct;
        status.timing_ok     = timing_ok;
        status.timeout       = (timeout_cnt >= 100);
        status.song_end      = pb_phase ? (addr >= 3) : (round_num >= 2);
    end

    // Set by a show phase, cleared once the player's turn is seen
    always @(posedge clock) begin
        if (reset || player_turn) shown_flag <= 1'b0;
        else if (ctrl.leds_from_memory) shown_flag <= 1'b1;
        if (reset) begin
            lost_pulses <= 0;
            step_pulses <= 0;
        end else begin
            if (lost) lost_pulses <= lost_pulses + 1;
            if (pb_phase && ctrl.step_addr) step_pulses <= step_pulses + 1;
        end
    end

    task automatic report_mismatch(input string name, input int exp, input int act);
        errors++;
        $display("Error %s: expected %0d, actual %0d", name, exp, act);
    endtask

    // ----------------------------------------
    // Assertions
    // ----------------------------------------

    a_cap_bpm: assert property (@(posedge clock) disable iff (reset)
        menu.capture_bpm == (menu.step == step_bpm))
        else report_mismatch("capture_bpm", int'(menu.step == step_bpm), int'(menu.capture_bpm));
    a_cap_tone: assert property (@(posedge clock) disable iff (reset)
        menu.capture_tone == (menu.step == step_tone))
        else report_mismatch("capture_tone", int'(menu.step == step_tone), int'(menu.capture_tone));
    a_cap_song: assert property (@(posedge clock) disable iff (reset)
        menu.capture_song == (menu.step == step_song))
        else report_mismatch("capture_song", int'(menu.step == step_song), int'(menu.capture_song));
    a_free_sound: assert property (@(posedge clock) disable iff (reset || !free_phase)
        ctrl.sound_on == $past(status.key_held))
        else report_mismatch("free_sound", int'($past(status.key_held)), int'(ctrl.sound_on));
    a_free_leds: assert property (@(posedge clock) disable iff (reset || !free_phase)
        ctrl.leds_on == $past(status.key_held))
        else report_mismatch("free_leds", int'($past(status.key_held)), int'(ctrl.leds_on));
    a_practice_result: assert property (@(posedge clock)
        disable iff (reset || !(free_phase || pb_phase)) !won && !lost)
        else report_mismatch("practice_won_lost", 0, int'(won | lost));
    a_lost_once: assert property (@(posedge clock) disable iff (reset) lost |=> !lost)
        else report_mismatch("lost_width", 0, int'(lost));
    a_lost_menu: assert property (@(posedge clock) disable iff (reset)
        lost |=> (menu.menu_open && menu.step == step_error))
        else report_mismatch("error_menu_open", int'(step_error), int'(menu.step));
    a_won_end: assert property (@(posedge clock) disable iff (reset)
        $rose(won) |-> $past(ctrl.step_round, 2))
        else report_mismatch("won_after_end_check", 1, 0);
    a_step_pulse: assert property (@(posedge clock) disable iff (reset || !pb_phase)
        ctrl.step_addr |=> !ctrl.step_addr)
        else report_mismatch("step_addr_width", 0, int'(ctrl.step_addr));
    a_step_shown: assert property (@(posedge clock) disable iff (reset || !pb_phase)
        (ctrl.leds_from_memory && status.note_shown) |=> ctrl.step_addr)
        else report_mismatch("step_after_shown", 1, int'(ctrl.step_addr));

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    task automatic apply_reset();
        reset = 1'b1;
        repeat (16) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic pulse_enter();
        @(negedge clock);
        enter = 1'b1;
        @(negedge clock);
        enter = 1'b0;
    endtask

    task automatic check_step(input string name, input menu_step_e exp);
        assert (menu.step == exp) else report_mismatch(name, int'(exp), int'(menu.step));
    endtask

    task automatic wait_menu(input string what, input menu_step_e e, input logic open);
        int k;
        k = 0;
        while (!(menu.step == e && menu.menu_open == open) && k < 100) begin
            @(negedge clock);
            k++;
        end
        if (k >= 100) begin
            errors++;
            $display("Timed out waiting for the %s menu", what);
        end
    endtask

    task automatic walk_menu(input mode_sel_t m);
        @(negedge clock);
        start = 1'b1;
        wait_menu("opening", step_none, 1'b1);
        start = 1'b0;
        wait_menu("mode", step_mode, 1'b0);
        choice.mode = m;
        pulse_enter();
        check_step("menu_bpm", step_bpm);
        pulse_enter();
        check_step("menu_tone", step_tone);
        pulse_enter();
        if (!m.free) begin
            check_step("menu_song", step_song);
            pulse_enter();
        end
        check_step("menu_run", step_none);
        choice = '0;
    endtask

    task automatic wait_turn(input string name, input int expect_show);
        int k;
        k = 0;
        while (!player_turn && !won && k < 300) begin
            @(negedge clock);
            k++;
        end
        if (k >= 300) begin
            errors++;
            $display("Timed out waiting for the player's turn in %s", name);
        end else if (player_turn && expect_show >= 0) begin
            assert (int'(shown_flag) == expect_show)
                else report_mismatch(name, expect_show, int'(shown_flag));
        end
    endtask

    task automatic press_key(input logic correct);
        @(negedge clock);
        key_correct = correct;
        timing_ok   = 1'b1;
        key_held    = 1'b1;
        repeat (2) @(negedge clock);
        key_held = 1'b0;
    endtask

    task automatic choose_retry(input retry_sel_t r);
        wait_menu("error", step_error, 1'b0);
        choice.retry = r;
        pulse_enter();
        choice = '0;
    endtask

    initial begin
        play_ctrl_t idle_ctrl;
        reset       = 1'b1;
        start       = 1'b0;
        enter       = 1'b0;
        choice      = '0;
        key_held    = 1'b0;
        key_correct = 1'b0;
        timing_ok   = 1'b0;
        free_phase  = 1'b0;
        pb_phase    = 1'b0;
        idle_ctrl   = '0;
        idle_ctrl.clear_key = 1'b1;

        apply_reset();
        assert (ctrl == idle_ctrl) else report_mismatch("reset_ctrl", int'(idle_ctrl), int'(ctrl));
        check_step("reset_menu", step_none);
        assert (!won && !lost && !player_turn)
            else report_mismatch("reset_flags", 0, int'({won, lost, player_turn}));

        // Round game with two misses, then a clean run to the end
        walk_menu(3'b001);
        wait_turn("first_turn", 1);
        press_key(1'b0);
        choose_retry(3'b010);
        wait_turn("retry_note", 0);
        press_key(1'b0);
        choose_retry(3'b100);
        wait_turn("replay_round", 1);
        n = 0;
        while (!won && n < 12) begin
            press_key(1'b1);
            wait_turn("game_turn", -1);
            n++;
        end
        assert (won) else report_mismatch("game_won", 1, int'(won));
        assert (lost_pulses == 2) else report_mismatch("lost_count", 2, lost_pulses);

        // Free play
        apply_reset();
        walk_menu(3'b010);
        free_phase = 1'b1;
        repeat (40) begin
            @(negedge clock);
            key_held = $random(seed) % 2 != 0;
        end
        @(negedge clock);
        key_held   = 1'b0;
        free_phase = 1'b0;

        // Playback
        apply_reset();
        walk_menu(3'b100);
        pb_phase = 1'b1;
        n = 0;
        while (step_pulses < 8 && n < 400) begin
            @(negedge clock);
            n++;
        end
        if (n >= 400) begin
            errors++;
            $display("Timed out waiting for playback notes");
        end
        pb_phase = 1'b0;

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Overall watchdog
    initial begin
        #2000000;
        $display("Simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/piano_ctrl_pkg.sv
// Piano control package: mode, menu choice, status and control types
`default_nettype none

package piano_ctrl_pkg;

    // ----------------------------------------
    // Menu choices
    // ----------------------------------------

    // One-hot, anything else counts as no mode
    typedef struct packed {
        logic playback;
        logic free;
        logic game;
    } mode_sel_t;

    // Priority from top to bottom
    typedef struct packed {
        logic replay_round;
        logic retry_note;
        logic show_last;
    } retry_sel_t;

    // Same switches, read by whichever menu is open
    typedef union packed {
        mode_sel_t  mode;
        retry_sel_t retry;
    } menu_choice_u;

    typedef enum logic [2:0] {
        step_none,
        step_mode,
        step_bpm,
        step_tone,
        step_song,
        step_error
    } menu_step_e;

    typedef struct packed {
        logic       menu_open;
        menu_step_e step;
        logic       capture_bpm;
        logic       capture_tone;
        logic       capture_song;
    } menu_ctrl_t;

    // ----------------------------------------
    // Datapath interface
    // ----------------------------------------

    typedef struct packed {
        logic pause_done;
        logic note_shown;
        logic addr_is_round;
        logic round_last;
        logic key_held;
        logic key_correct;
        logic timing_ok;
        logic timeout;
        logic song_end;
    } play_status_t;

    typedef struct packed {
        logic clear_addr;
        logic step_addr;
        logic clear_pause;
        logic count_pause;
        logic clear_round;
        logic step_round;
        logic clear_metro;
        logic count_metro;
        logic clear_timeout;
        logic count_timeout;
        logic clear_key;
        logic capture_key;
        logic leds_on;
        logic leds_from_memory;
        logic sound_on;
    } play_ctrl_t;

endpackage

`default_nettype wire

//--- hw/piano_ctrl_top.sv
// Piano control unit top: setup menu plus game and practice sequencers
`timescale 1ns/1ps
`default_nettype none

module piano_ctrl_top
    import piano_ctrl_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         start,
    input  wire logic         enter,
    input  wire menu_choice_u choice,
    input  wire play_status_t status,
    output play_ctrl_t        ctrl,
    output menu_ctrl_t        menu,
    output logic              won,
    output logic              lost,
    output logic              player_turn
);

    menu_ctrl_t setup_menu_ctrl;
    menu_ctrl_t game_menu_ctrl;
    mode_sel_t  mode;
    logic       run;
    play_ctrl_t game_ctrl;
    play_ctrl_t practice_ctrl;

    setup_menu setup_menu_i (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .enter  (enter),
        .choice (choice),
        .menu   (setup_menu_ctrl),
        .mode   (mode),
        .run    (run)
    );

    round_game_fsm round_game_fsm_i (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .enter       (enter),
        .run         (run),
        .mode        (mode),
        .choice      (choice),
        .status      (status),
        .ctrl        (game_ctrl),
        .menu        (game_menu_ctrl),
        .won         (won),
        .lost        (lost),
        .player_turn (player_turn)
    );

    practice_fsm practice_fsm_i (
        .clock  (clock),
        .reset  (reset),
        .run    (run),
        .mode   (mode),
        .status (status),
        .ctrl   (practice_ctrl)
    );

    // Idle sequencers drive zeros, so OR is enough
    always_comb begin
        ctrl = play_ctrl_t'(game_ctrl | practice_ctrl);
        // Key register held clear until play starts
        ctrl.clear_key = ctrl.clear_key | ~run;
    end

    assign menu = (game_menu_ctrl.step != step_none) ? game_menu_ctrl : setup_menu_ctrl;

endmodule

`default_nettype wire

//--- hw/practice_fsm.sv
// Practice sequencer: free play on held keys and endless song playback
`timescale 1ns/1ps
`default_nettype none

module practice_fsm
    import piano_ctrl_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         run,
    input  wire mode_sel_t    mode,
    input  wire play_status_t status,
    output play_ctrl_t        ctrl
);

    typedef enum logic [2:0] {
        st_idle,
        st_free_wait,
        st_free_key,
        st_pb_init,
        st_pb_pause,
        st_pb_note,
        st_pb_step
    } state_e;

    state_e state;
    state_e state_next;
    logic   free_sel;
    logic   playback_sel;

    assign free_sel     = run && mode.free && !mode.game && !mode.playback;
    assign playback_sel = run && mode.playback && !mode.game && !mode.free;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (free_sel) begin
                    state_next = st_free_wait;
                end else if (playback_sel) begin
                    state_next = st_pb_init;
                end
            end
            st_free_wait: if (status.key_held) state_next = st_free_key;
            st_free_key:  if (!status.key_held) state_next = st_free_wait;
            st_pb_init:   state_next = st_pb_pause;
            st_pb_pause:  if (status.pause_done) state_next = st_pb_note;
            st_pb_note:   if (status.note_shown) state_next = st_pb_step;
            // Last note played, go round again from the top
            st_pb_step:   state_next = status.song_end ? st_pb_init : st_pb_note;
            default:      state_next = st_idle;
        endcase

        if (!free_sel && !playback_sel) begin
            state_next = st_idle;
        end
    end

    // ----------------------------------------
    // Moore decode
    // ----------------------------------------

    always_comb begin
        ctrl = '0;
        case (state)
            st_free_key: begin
                ctrl.sound_on    = 1'b1;
                ctrl.leds_on     = 1'b1;
                ctrl.capture_key = 1'b1;
            end
            st_pb_init: begin
                ctrl.clear_addr  = 1'b1;
                ctrl.clear_pause = 1'b1;
                ctrl.clear_metro = 1'b1;
            end
            st_pb_pause:  ctrl.count_pause = 1'b1;
            st_pb_note: begin
                ctrl.sound_on         = 1'b1;
                ctrl.leds_on          = 1'b1;
                ctrl.leds_from_memory = 1'b1;
                ctrl.count_metro      = 1'b1;
            end
            st_pb_step: begin
                ctrl.step_addr   = 1'b1;
                ctrl.clear_metro = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/round_game_fsm.sv
// Round game sequencer: show a growing melody, check the answer, error menu
`timescale 1ns/1ps
`default_nettype none

module round_game_fsm
    import piano_ctrl_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         start,
    input  wire logic         enter,
    input  wire logic         run,
    input  wire mode_sel_t    mode,
    input  wire menu_choice_u choice,
    input  wire play_status_t status,
    output play_ctrl_t        ctrl,
    output menu_ctrl_t        menu,
    output logic              won,
    output logic              lost,
    output logic              player_turn
);

    typedef enum logic [4:0] {
        st_idle,
        st_init,
        st_round_start,
        st_show,
        st_show_step,
        st_show_done,
        st_wait,
        st_key,
        st_compare,
        st_next_note,
        st_next_round,
        st_end_check,
        st_lose,
        st_err_open,
        st_err_menu,
        st_show_last,
        st_won
    } state_e;

    state_e     state;
    state_e     state_next;
    logic       enable;
    retry_sel_t retry;

    assign enable = run && mode.game && !mode.free && !mode.playback;
    assign retry  = choice.retry;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            st_idle:        state_next = st_init;
            st_init:        state_next = st_round_start;
            st_round_start: if (status.pause_done) state_next = st_show;
            st_show: begin
                if (status.note_shown) begin
                    state_next = status.addr_is_round ? st_show_done : st_show_step;
                end
            end
            st_show_step:   state_next = st_show;
            st_show_done:   state_next = st_wait;
            st_wait: begin
                if (status.timeout) begin
                    state_next = st_lose;
                end else if (status.key_held) begin
                    state_next = st_key;
                end
            end
            st_key:         if (!status.key_held) state_next = st_compare;
            st_compare: begin
                if (!status.key_correct || !status.timing_ok) begin
                    state_next = st_lose;
                end else if (!status.addr_is_round) begin
                    state_next = st_next_note;
                end else if (status.round_last) begin
                    state_next = st_won;
                end else begin
                    state_next = st_next_round;
                end
            end
            st_next_note:   state_next = st_wait;
            st_next_round:  state_next = st_end_check;
            st_end_check:   state_next = status.song_end ? st_won : st_round_start;
            st_lose:        state_next = st_err_open;
            st_err_open:    state_next = st_err_menu;
            st_err_menu: begin
                // Enter with nothing selected leaves the menu open
                if (enter) begin
                    if (retry.replay_round) begin
                        state_next = st_round_start;
                    end else if (retry.retry_note) begin
                        state_next = st_wait;
                    end else if (retry.show_last) begin
                        state_next = st_show_last;
                    end
                end
            end
            st_show_last:   if (status.note_shown) state_next = st_wait;
            st_won:         if (start) state_next = st_init;
            default:        state_next = st_idle;
        endcase

        if (!enable) begin
            state_next = st_idle;
        end
    end

    // ----------------------------------------
    // Moore decode
    // ----------------------------------------

    always_comb begin
        ctrl = '0;
        case (state)
            st_init: begin
                ctrl.clear_round   = 1'b1;
                ctrl.clear_pause   = 1'b1;
                ctrl.clear_metro   = 1'b1;
                ctrl.clear_timeout = 1'b1;
            end
            st_round_start: begin
                ctrl.clear_addr  = 1'b1;
                ctrl.count_pause = 1'b1;
                ctrl.clear_metro = 1'b1;
            end
            st_show, st_show_last: begin
                ctrl.leds_on          = 1'b1;
                ctrl.leds_from_memory = 1'b1;
                ctrl.count_metro      = 1'b1;
                ctrl.clear_pause      = 1'b1;
            end
            st_show_step: begin
                ctrl.step_addr   = 1'b1;
                ctrl.clear_metro = 1'b1;
            end
            st_show_done: begin
                ctrl.clear_addr    = 1'b1;
                ctrl.clear_timeout = 1'b1;
            end
            st_wait: begin
                ctrl.count_timeout = 1'b1;
                ctrl.clear_metro   = 1'b1;
            end
            st_key: begin
                ctrl.sound_on    = 1'b1;
                ctrl.leds_on     = 1'b1;
                ctrl.capture_key = 1'b1;
                ctrl.count_metro = 1'b1;
            end
            st_next_note: begin
                ctrl.step_addr     = 1'b1;
                ctrl.clear_timeout = 1'b1;
            end
            st_next_round:  ctrl.step_round = 1'b1;
            st_end_check: begin
                ctrl.clear_timeout = 1'b1;
                ctrl.clear_metro   = 1'b1;
            end
            st_lose:        ctrl.clear_timeout = 1'b1;
            st_err_open:    ctrl.clear_metro = 1'b1;
            default: ;
        endcase
    end

    // Error menu shows step error from the opening pulse on
    always_comb begin
        menu = '0;
        menu.step = step_none;
        if (state == st_err_open) begin
            menu.menu_open = 1'b1;
            menu.step      = step_error;
        end else if (state == st_err_menu) begin
            menu.step = step_error;
        end
    end

    assign won         = (state == st_won);
    assign lost        = (state == st_lose);
    assign player_turn = (state == st_wait);

endmodule

`default_nettype wire

//--- hw/setup_menu.sv
// Setup menu: walks mode, tempo, tone and song, then holds the chosen mode
`timescale 1ns/1ps
`default_nettype none

module setup_menu
    import piano_ctrl_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         start,
    input  wire logic         enter,
    input  wire menu_choice_u choice,
    output menu_ctrl_t        menu,
    output mode_sel_t         mode,
    output logic              run
);

    typedef enum logic [2:0] {
        st_idle,
        st_open,
        st_mode,
        st_bpm,
        st_tone,
        st_song,
        st_run
    } state_e;

    state_e state;
    state_e state_next;
    logic   free_only;

    // Free play skips the song step
    assign free_only = mode.free && !mode.game && !mode.playback;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Mode is latched on the enter that leaves the mode step
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mode <= '0;
        end else if (state == st_mode && enter) begin
            mode <= choice.mode;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: if (start) state_next = st_open;
            st_open: state_next = st_mode;
            st_mode: if (enter) state_next = st_bpm;
            st_bpm:  if (enter) state_next = st_tone;
            st_tone: begin
                if (enter) begin
                    state_next = free_only ? st_run : st_song;
                end
            end
            st_song: if (enter) state_next = st_run;
            st_run:  state_next = st_run;
            default: state_next = st_idle;
        endcase
    end

    // ----------------------------------------
    // Moore decode
    // ----------------------------------------

    always_comb begin
        menu = '0;
        menu.step = step_none;
        case (state)
            st_open: menu.menu_open = 1'b1;
            st_mode: menu.step = step_mode;
            st_bpm: begin
                menu.step        = step_bpm;
                menu.capture_bpm = 1'b1;
            end
            st_tone: begin
                menu.step         = step_tone;
                menu.capture_tone = 1'b1;
            end
            st_song: begin
                menu.step         = step_song;
                menu.capture_song = 1'b1;
            end
            default: ;
        endcase
    end

    assign run = (state == st_run);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module piano_ctrl_tb -o piano_ctrl_sim \
    || exit 1
out=$(./obj_dir/piano_ctrl_sim)
echo "$out"
echo "$out" | grep -qx "test passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- vlog.f
hw/piano_ctrl_pkg.sv
hw/setup_menu.sv
hw/round_game_fsm.sv
hw/practice_fsm.sv
hw/piano_ctrl_top.sv
dv/piano_ctrl_tb.sv
